//--- all.f
+incdir+.
mc_pkg.sv
if_stage.sv
id_stage.sv
exe_stage.sv
wb_stage.sv
mc_core.sv
mc_asserts.sv
mc_checker.sv
tb_mc_core.sv

//--- exe_stage.sv
// execute stage with operand capture, result register, write enable and jump decision.
`include "mc_defs.svh"

module exe_stage import mc_pkg::*; (
  input  logic clk,
  input  logic rst,
  input  cnt_t cnt_i,
  input  dec_t dec_i,
  output wb_t  wb_o,
  output jmp_t jmp_o
);

  dec_t  dec_q;
  xlen_t rd_data;
  logic  writes;
  jmp_t  jmp_d;
  jmp_t  jmp_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      dec_q <= '0;
    end else if (cnt_i == `SLOT_CAPTURE) begin
      dec_q <= dec_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_data <= '0;
    end else if (cnt_i == `SLOT_EXEC) begin
      case (dec_q.opcode)
        `OPCODE_AUIPC: rd_data <= dec_q.op1 + dec_q.op2;
        `OPCODE_ADDI: begin
          case (dec_q.funct3)
            `FUNCT3_ADDI:  rd_data <= dec_q.op1 + dec_q.op2;
            `FUNCT3_SLTI:  rd_data <= xlen_t'($signed(dec_q.op1) < $signed(dec_q.op2));
            `FUNCT3_SLTIU: rd_data <= xlen_t'(dec_q.op1 < dec_q.op2);
            default:       rd_data <= '0;
          endcase
        end
        `OPCODE_JAL:  rd_data <= dec_q.op1;
        `OPCODE_JALR: rd_data <= dec_q.t1;
        default:      rd_data <= '0;
      endcase
    end
  end

  // only the supported op-imm codes write, other funct3 values fall through as no-ops.
  always_comb begin
    case (dec_q.opcode)
      `OPCODE_AUIPC, `OPCODE_JAL, `OPCODE_JALR: writes = 1'b1;
      `OPCODE_ADDI: writes = (dec_q.funct3 == `FUNCT3_ADDI) ||
                             (dec_q.funct3 == `FUNCT3_SLTI) ||
                             (dec_q.funct3 == `FUNCT3_SLTIU);
      default: writes = 1'b0;
    endcase
  end

  always_comb begin
    jmp_d.taken = 1'b0;
    jmp_d.addr  = dec_q.t1;
    case (dec_q.opcode)
      `OPCODE_JAL: begin
        jmp_d.taken = 1'b1;
        jmp_d.addr  = dec_q.op2;
      end
      `OPCODE_JALR: begin
        jmp_d.taken = 1'b1;
        jmp_d.addr  = (dec_q.op1 + dec_q.op2) & ~xlen_t'(1);
      end
      `OPCODE_BRANCH: begin
        case (dec_q.funct3)
          `FUNCT3_BEQ:  jmp_d.taken = (dec_q.op1 == dec_q.op2);
          `FUNCT3_BNE:  jmp_d.taken = (dec_q.op1 != dec_q.op2);
          `FUNCT3_BLT:  jmp_d.taken = ($signed(dec_q.op1) <  $signed(dec_q.op2));
          `FUNCT3_BGE:  jmp_d.taken = ($signed(dec_q.op1) >= $signed(dec_q.op2));
          `FUNCT3_BLTU: jmp_d.taken = (dec_q.op1 <  dec_q.op2);
          `FUNCT3_BGEU: jmp_d.taken = (dec_q.op1 >= dec_q.op2);
          default:      jmp_d.taken = 1'b0;
        endcase
      end
      default: ;
    endcase
  end

  // refreshed every cycle, so it settles one cycle after the capture slot.
  always_ff @(posedge clk) begin
    if (rst) begin
      jmp_q <= '0;
    end else begin
      jmp_q <= jmp_d;
    end
  end

  assign wb_o.wen  = ((cnt_i == `SLOT_WB0) || (cnt_i == `SLOT_WB1)) &&
                     writes && (dec_q.rd != '0);
  assign wb_o.rd   = dec_q.rd;
  assign wb_o.data = rd_data;
  assign jmp_o     = jmp_q;

endmodule

//--- id_stage.sv
// instruction field split, immediate generation, register reads and operand selection.
`include "mc_defs.svh"

module id_stage import mc_pkg::*; (
  input  inst_t     inst_i,
  input  xlen_t     pc_i,
  output reg_addr_t rs1_addr_o,
  output reg_addr_t rs2_addr_o,
  input  xlen_t     rs1_data_i,
  input  xlen_t     rs2_data_i,
  output dec_t      dec_o
);

  opcode_t opcode;
  xlen_t   imm_i;
  xlen_t   imm_u;
  xlen_t   imm_j;
  xlen_t   imm_b;
  xlen_t   pc_plus4;
  xlen_t   op1;
  xlen_t   op2;
  xlen_t   t1;

  assign opcode     = inst_i[6:2];
  assign rs1_addr_o = inst_i[19:15];
  assign rs2_addr_o = inst_i[24:20];

  // sign-extended immediates of the four formats in use.
  assign imm_i = {{(`XLEN-12){inst_i[31]}}, inst_i[31:20]};
  assign imm_u = {{(`XLEN-32){inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_j = {{(`XLEN-21){inst_i[31]}}, inst_i[31], inst_i[19:12],
                  inst_i[20], inst_i[30:21], 1'b0};
  assign imm_b = {{(`XLEN-13){inst_i[31]}}, inst_i[31], inst_i[7],
                  inst_i[30:25], inst_i[11:8], 1'b0};

  assign pc_plus4 = pc_i + xlen_t'(4);

  always_comb begin
    op1 = '0;
    op2 = '0;
    t1  = '0;
    case (opcode)
      `OPCODE_AUIPC: begin
        op1 = pc_i;
        op2 = imm_u;
      end
      `OPCODE_ADDI: begin
        op1 = rs1_data_i;
        op2 = imm_i;
      end
      `OPCODE_JAL: begin
        op1 = pc_plus4;        // link value.
        op2 = pc_i + imm_j;    // jump target.
      end
      `OPCODE_JALR: begin
        op1 = rs1_data_i;
        op2 = imm_i;
        t1  = pc_plus4;
      end
      `OPCODE_BRANCH: begin
        op1 = rs1_data_i;
        op2 = rs2_data_i;
        t1  = pc_i + imm_b;
      end
      default: ;
    endcase
  end

  assign dec_o.opcode = opcode;
  assign dec_o.funct3 = inst_i[14:12];
  assign dec_o.funct7 = inst_i[31:25];
  assign dec_o.op1    = op1;
  assign dec_o.op2    = op2;
  assign dec_o.t1     = t1;
  assign dec_o.rd     = inst_i[11:7];

endmodule

//--- if_stage.sv
// instruction cycle counter, program counter and instruction register.
`include "mc_defs.svh"

module if_stage import mc_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  inst_t inst_i,
  input  jmp_t  jmp_i,
  output cnt_t  cnt_o,
  output xlen_t pc_o,
  output inst_t inst_o,
  output logic  fetch_o
);

  cnt_t  cnt_q;
  xlen_t pc_q;
  inst_t ir_q;
  xlen_t pc_next;

  // the jump bundle is settled well before the last slot.
  assign pc_next = jmp_i.taken ? jmp_i.addr : pc_q + xlen_t'(4);

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= '0;
      pc_q  <= '0;
    end else begin
      cnt_q <= cnt_q + cnt_t'(1); // wraps from 7 back to 0.
      if (cnt_q == `SLOT_WB1) begin
        pc_q <= pc_next;
      end
    end
  end

  // the instruction port is held stable through slots 1 and 2.
  always_ff @(posedge clk) begin
    if (cnt_q == `SLOT_INST) begin
      ir_q <= inst_i;
    end
  end

  assign cnt_o   = cnt_q;
  assign pc_o    = pc_q;
  assign inst_o  = ir_q;
  assign fetch_o = (cnt_q == `SLOT_FETCH);

endmodule

//--- mc_asserts.sv
// timing assertions on the core ports, and their bind to the core.
module mc_asserts import mc_pkg::*; (
  input logic  clk,
  input logic  rst,
  input logic  fetch_i,
  input xlen_t pc_i,
  input logic  wen_i
);

  // a strobe is followed by the next one exactly 8 cycles later.
  fetch_next: assert property (@(posedge clk) disable iff (rst) fetch_i |-> ##8 fetch_i)
    else $error("fetch strobe did not recur after 8 cycles");

  // writeback belongs to the 6th and 7th cycle after the strobe.
  wen_slots: assert property (@(posedge clk) disable iff (rst)
    wen_i |-> ($past(fetch_i, 6) || $past(fetch_i, 7)))
    else $error("write enable outside the writeback slots");

  // the pc only moves into a new fetch slot.
  pc_stable: assert property (@(posedge clk) disable iff (rst) !fetch_i |-> $stable(pc_i))
    else $error("pc changed between fetch strobes");

endmodule

bind mc_core mc_asserts u_asserts (
  .clk     (clk),
  .rst     (rst),
  .fetch_i (fetch_o),
  .pc_i    (pc_o),
  .wen_i   (wb_o.wen)
);

//--- mc_checker.sv
// checker that compares the core writeback and pc with queued expectations.
module mc_checker import mc_pkg::*; (
  input logic  clk,
  input logic  rst,
  input logic  fetch_i,
  input xlen_t pc_i,
  input wb_t   wb_i
);

  string     name_q[$];
  logic      wen_q[$];
  reg_addr_t rd_q[$];
  xlen_t     data_q[$];
  xlen_t     npc_q[$];
  bit        bad_q[$];

  int fetch_cnt;
  int slot;
  int idx;
  int n_pass = 0;
  int n_fail = 0;
  int n_err = 0;
  int n_done = 0;

  task automatic add_expect(string name, logic wen, reg_addr_t rd, xlen_t data, xlen_t npc);
    name_q.push_back(name);
    wen_q.push_back(wen);
    rd_q.push_back(rd);
    data_q.push_back(data);
    npc_q.push_back(npc);
    bad_q.push_back(1'b0);
  endtask

  // sampled on the falling edge, half a cycle away from any change.
  always @(negedge clk) begin
    if (rst) begin
      fetch_cnt = 0;
      slot = 0;
    end else if (fetch_i) begin
      idx = fetch_cnt - 1;
      if (fetch_cnt == 0) begin
        if (pc_i != '0) begin
          $display("** Error reset_pc: expected %h, actual %h", 64'h0, pc_i);
          n_err++;
        end
      end else if (idx < name_q.size()) begin
        if (pc_i != npc_q[idx]) begin
          $display("** Error %s: next pc expected %h, actual %h", name_q[idx], npc_q[idx], pc_i);
          bad_q[idx] = 1'b1;
        end
        if (bad_q[idx]) begin
          $display("test %s: fail", name_q[idx]);
          n_fail++;
        end else begin
          $display("test %s: pass", name_q[idx]);
          n_pass++;
        end
        n_done++;
      end
      fetch_cnt++;
      slot = 0;
    end else begin
      slot++;
      if (slot == 8) begin
        $display("no fetch strobe seen for 8 cycles after fetch %0d", fetch_cnt);
        n_err++;
      end
      idx = fetch_cnt - 1;
      if (slot == 6 && idx >= 0 && idx < name_q.size()) begin
        if (wb_i.wen !== wen_q[idx]) begin
          $display("** Error %s: wen expected %b, actual %b", name_q[idx], wen_q[idx], wb_i.wen);
          bad_q[idx] = 1'b1;
        end else if (wen_q[idx]) begin
          if (wb_i.rd !== rd_q[idx]) begin
            $display("** Error %s: rd expected %0d, actual %0d", name_q[idx], rd_q[idx], wb_i.rd);
            bad_q[idx] = 1'b1;
          end
          if (wb_i.data !== data_q[idx]) begin
            $display("** Error %s: data expected %h, actual %h",
                     name_q[idx], data_q[idx], wb_i.data);
            bad_q[idx] = 1'b1;
          end
        end
      end
    end
  end

endmodule

//--- mc_core.sv
// top level of the multi-cycle core, joining fetch, decode, execute and writeback.
module mc_core import mc_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  inst_t inst_i,
  output logic  fetch_o,
  output xlen_t pc_o,
  output wb_t   wb_o
);

  cnt_t      cnt;
  xlen_t     pc;
  inst_t     inst;
  jmp_t      jmp;
  dec_t      dec;
  wb_t       exe_wb;
  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  xlen_t     rs1_data;
  xlen_t     rs2_data;

  if_stage u_if (
    .clk     (clk),
    .rst     (rst),
    .inst_i  (inst_i),
    .jmp_i   (jmp),
    .cnt_o   (cnt),
    .pc_o    (pc),
    .inst_o  (inst),
    .fetch_o (fetch_o)
  );

  id_stage u_id (
    .inst_i     (inst),
    .pc_i       (pc),
    .rs1_addr_o (rs1_addr),
    .rs2_addr_o (rs2_addr),
    .rs1_data_i (rs1_data),
    .rs2_data_i (rs2_data),
    .dec_o      (dec)
  );

  exe_stage u_exe (
    .clk   (clk),
    .rst   (rst),
    .cnt_i (cnt),
    .dec_i (dec),
    .wb_o  (exe_wb),
    .jmp_o (jmp)
  );

  wb_stage u_wb (
    .clk        (clk),
    .rst        (rst),
    .wb_i       (exe_wb),
    .cnt_i      (cnt),
    .rs1_addr_i (rs1_addr),
    .rs2_addr_i (rs2_addr),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wb_o       (wb_o)
  );

  assign pc_o = pc;

endmodule

//--- mc_defs.svh
// widths, opcode and funct3 codes, and the cycle counter slots of the core.
`ifndef MC_DEFS_SVH
`define MC_DEFS_SVH

// data path and instruction widths.
`define XLEN    64
`define INST_W  32
`define REG_AW  5

// counter width, 8 cycles per instruction.
`define CNT_W   3

// major opcodes, taken from instruction bits 6 to 2.
`define OPCODE_AUIPC   5'b00101
`define OPCODE_ADDI    5'b00100 // the whole op-imm group.
`define OPCODE_JAL     5'b11011
`define OPCODE_JALR    5'b11001
`define OPCODE_BRANCH  5'b11000

// op-imm function codes.
`define FUNCT3_ADDI    3'b000
`define FUNCT3_SLTI    3'b010
`define FUNCT3_SLTIU   3'b011

// branch function codes.
`define FUNCT3_BEQ     3'b000
`define FUNCT3_BNE     3'b001
`define FUNCT3_BLT     3'b100
`define FUNCT3_BGE     3'b101
`define FUNCT3_BLTU    3'b110
`define FUNCT3_BGEU    3'b111

// counter values that mark events inside one instruction.
// the fetch strobe is up in slot 0.
`define SLOT_FETCH     3'd0
// instruction register loads at the end of this slot.
`define SLOT_INST      3'd2
`define SLOT_CAPTURE   3'd3 // execute captures the decoded bundle.
`define SLOT_EXEC      3'd4 // result register loads.
// writeback is visible in these two slots, the register file is written in the last.
`define SLOT_WB0       3'd6
`define SLOT_WB1       3'd7

`endif

//--- mc_pkg.sv
// vector types and the bundles passed between the core stages.
`include "mc_defs.svh"

package mc_pkg;

  // plain vectors with a meaning.
  typedef logic [`XLEN-1:0]   xlen_t;     // data, pc or address.
  typedef logic [`INST_W-1:0] inst_t;
  typedef logic [`REG_AW-1:0] reg_addr_t;
  typedef logic [`CNT_W-1:0]  cnt_t;
  typedef logic [4:0]         opcode_t;
  typedef logic [2:0]         funct3_t;

  // decoded instruction with its selected operands.
  // t1 carries the return address for jalr and the target for branches.
  typedef struct packed {
    opcode_t   opcode;
    funct3_t   funct3;
    logic [6:0] funct7;
    xlen_t     op1;
    xlen_t     op2;
    xlen_t     t1;
    reg_addr_t rd;
  } dec_t;

  // one register file write.
  typedef struct packed {
    logic      wen;
    reg_addr_t rd;
    xlen_t     data;
  } wb_t;

  // redirect of the program counter.
  typedef struct packed {
    logic  taken;
    xlen_t addr;
  } jmp_t;

endpackage

//--- run.sh
#!/usr/bin/env bash
# builds the core testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_mc_core \
  -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Everything OK$" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

//--- tb_mc_core.sv
// testbench top with clock, reset, instruction stream, reference model and run control.
`include "mc_defs.svh"

module tb_mc_core import mc_pkg::*; ();

  typedef struct packed {
    logic      wen;
    reg_addr_t rd;
    xlen_t     data;
    xlen_t     npc;
  } exp_t;

  logic  clk;
  logic  rst;
  inst_t inst_i;
  logic  fetch_o;
  xlen_t pc_o;
  wb_t   wb_o;

  inst_t prog[$];
  string names[$];
  xlen_t mregs [0:31];
  xlen_t mpc;
  int    cycles = 0;
  int    limit = 0;

  mc_core u_dut (
    .clk     (clk),
    .rst     (rst),
    .inst_i  (inst_i),
    .fetch_o (fetch_o),
    .pc_o    (pc_o),
    .wb_o    (wb_o)
  );

  mc_checker u_chk (
    .clk     (clk),
    .rst     (rst),
    .fetch_i (fetch_o),
    .pc_i    (pc_o),
    .wb_i    (wb_o)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic inst_t enc_i(opcode_t op, funct3_t f3, reg_addr_t rd, reg_addr_t rs1,
                                  logic [11:0] imm);
    return {imm, rs1, f3, rd, op, 2'b11};
  endfunction

  function automatic inst_t enc_u(reg_addr_t rd, logic [19:0] imm);
    return {imm, rd, `OPCODE_AUIPC, 2'b11};
  endfunction

  function automatic inst_t enc_j(reg_addr_t rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, `OPCODE_JAL, 2'b11};
  endfunction

  function automatic inst_t enc_b(funct3_t f3, reg_addr_t rs1, reg_addr_t rs2, logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPCODE_BRANCH, 2'b11};
  endfunction

  task automatic add(string name, inst_t inst);
    names.push_back(name);
    prog.push_back(inst);
  endtask

  // architectural model, it advances the model registers and pc by one instruction.
  function automatic exp_t ref_exec(inst_t inst);
    opcode_t   opc;
    funct3_t   f3;
    reg_addr_t rs1;
    reg_addr_t rs2;
    xlen_t     a;
    xlen_t     b;
    xlen_t     imm_i;
    xlen_t     imm_u;
    xlen_t     imm_j;
    xlen_t     imm_b;
    logic      taken;
    exp_t      e;
    opc = inst[6:2];
    f3  = inst[14:12];
    rs1 = inst[19:15];
    rs2 = inst[24:20];
    a = (rs1 == 0) ? '0 : mregs[rs1];
    b = (rs2 == 0) ? '0 : mregs[rs2];
    imm_i = {{52{inst[31]}}, inst[31:20]};
    imm_u = {{32{inst[31]}}, inst[31:12], 12'h000};
    imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
    imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    taken = 1'b0;
    e = '0;
    e.rd = inst[11:7];
    e.npc = mpc + 64'd4;
    case (opc)
      `OPCODE_AUIPC: begin
        e.wen = 1'b1;
        e.data = mpc + imm_u;
      end
      `OPCODE_ADDI: begin
        e.wen = 1'b1;
        case (f3)
          `FUNCT3_ADDI:  e.data = a + imm_i;
          `FUNCT3_SLTI:  e.data = {63'b0, $signed(a) < $signed(imm_i)};
          `FUNCT3_SLTIU: e.data = {63'b0, a < imm_i};
          default:       e.wen = 1'b0;
        endcase
      end
      `OPCODE_JAL: begin
        e.wen = 1'b1;
        e.data = mpc + 64'd4;
        e.npc = mpc + imm_j;
      end
      `OPCODE_JALR: begin
        e.wen = 1'b1;
        e.data = mpc + 64'd4;
        e.npc = (a + imm_i) & ~64'd1;
      end
      `OPCODE_BRANCH: begin
        case (f3)
          `FUNCT3_BEQ:  taken = (a == b);
          `FUNCT3_BNE:  taken = (a != b);
          `FUNCT3_BLT:  taken = ($signed(a) < $signed(b));
          `FUNCT3_BGE:  taken = ($signed(a) >= $signed(b));
          `FUNCT3_BLTU: taken = (a < b);
          `FUNCT3_BGEU: taken = (a >= b);
          default:      taken = 1'b0;
        endcase
        if (taken) e.npc = mpc + imm_b;
      end
      default: ;
    endcase
    if (e.rd == 0) e.wen = 1'b0; // x0 is never written.
    if (e.wen) mregs[e.rd] = e.data;
    mpc = e.npc;
    return e;
  endfunction

  task automatic build_program();
    funct3_t   bf [0:5];
    reg_addr_t rd;
    reg_addr_t rs1;
    reg_addr_t rs2;
    int        k;
    bf = '{`FUNCT3_BEQ, `FUNCT3_BNE, `FUNCT3_BLT, `FUNCT3_BGE, `FUNCT3_BLTU, `FUNCT3_BGEU};
    add("auipc", enc_u(5'd1, 20'($urandom)));
    add("addi_neg", enc_i(`OPCODE_ADDI, `FUNCT3_ADDI, 5'd2, 5'd0, 12'hffb));
    add("addi_rand", enc_i(`OPCODE_ADDI, `FUNCT3_ADDI, 5'd3, 5'd2, 12'($urandom)));
    add("addi_minus1", enc_i(`OPCODE_ADDI, `FUNCT3_ADDI, 5'd4, 5'd0, 12'hfff));
    add("slti_true", enc_i(`OPCODE_ADDI, `FUNCT3_SLTI, 5'd5, 5'd4, 12'd1));
    add("sltiu_false", enc_i(`OPCODE_ADDI, `FUNCT3_SLTIU, 5'd6, 5'd4, 12'd1));
    add("sltiu_true", enc_i(`OPCODE_ADDI, `FUNCT3_SLTIU, 5'd7, 5'd0, 12'hfff));
    add("slti_false", enc_i(`OPCODE_ADDI, `FUNCT3_SLTI, 5'd8, 5'd0, 12'hfff));
    add("jal", enc_j(5'd1, 21'd16));
    add("jalr_odd", enc_i(`OPCODE_JALR, 3'b000, 5'd9, 5'd2, 12'd8)); // -5 + 8 lands on 3.
    add("addi_one", enc_i(`OPCODE_ADDI, `FUNCT3_ADDI, 5'd10, 5'd0, 12'd1));
    add("beq_taken", enc_b(`FUNCT3_BEQ, 5'd10, 5'd10, 13'd8));
    add("bne_not", enc_b(`FUNCT3_BNE, 5'd10, 5'd10, 13'd8));
    add("blt_taken", enc_b(`FUNCT3_BLT, 5'd4, 5'd10, 13'h1ff4));
    add("bge_not", enc_b(`FUNCT3_BGE, 5'd4, 5'd10, 13'd12));
    add("bltu_not", enc_b(`FUNCT3_BLTU, 5'd4, 5'd10, 13'd12));
    add("bgeu_taken", enc_b(`FUNCT3_BGEU, 5'd4, 5'd10, 13'd20));
    add("blt_not", enc_b(`FUNCT3_BLT, 5'd10, 5'd4, 13'd8));
    add("bltu_taken", enc_b(`FUNCT3_BLTU, 5'd10, 5'd4, 13'd24));
    add("bge_taken", enc_b(`FUNCT3_BGE, 5'd10, 5'd4, 13'h1ff8));
    add("bgeu_not", enc_b(`FUNCT3_BGEU, 5'd10, 5'd4, 13'd8));
    add("addi_x0", enc_i(`OPCODE_ADDI, `FUNCT3_ADDI, 5'd0, 5'd10, 12'd55));
    add("unsupported", 32'h00a5_05b3); // register add into x11.
    add("read_x0", enc_i(`OPCODE_ADDI, `FUNCT3_ADDI, 5'd11, 5'd0, 12'd77));
    for (int i = 0; i < 200; i++) begin
      k = int'($urandom_range(0, 7));
      rd = reg_addr_t'($urandom_range(0, 15));
      rs1 = reg_addr_t'($urandom_range(0, 15));
      rs2 = reg_addr_t'($urandom_range(0, 15));
      case (k)
        0: add($sformatf("rand_%0d_auipc", i), enc_u(rd, 20'($urandom)));
        1: add($sformatf("rand_%0d_addi", i),
               enc_i(`OPCODE_ADDI, `FUNCT3_ADDI, rd, rs1, 12'($urandom)));
        2: add($sformatf("rand_%0d_slti", i),
               enc_i(`OPCODE_ADDI, `FUNCT3_SLTI, rd, rs1, 12'($urandom)));
        3: add($sformatf("rand_%0d_sltiu", i),
               enc_i(`OPCODE_ADDI, `FUNCT3_SLTIU, rd, rs1, 12'($urandom)));
        4: add($sformatf("rand_%0d_jal", i), enc_j(rd, {20'($urandom), 1'b0}));
        5: add($sformatf("rand_%0d_jalr", i),
               enc_i(`OPCODE_JALR, 3'b000, rd, rs1, 12'($urandom)));
        6: add($sformatf("rand_%0d_branch", i),
               enc_b(bf[$urandom_range(0, 5)], rs1, rs2, {12'($urandom), 1'b0}));
        default: add($sformatf("rand_%0d_nop", i), {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011});
      endcase
    end
  endtask

  // the limit follows the program length, 8 cycles per instruction.
  initial begin
    forever begin
      @(posedge clk);
      cycles++;
      if (limit > 0 && cycles > limit) begin
        $display("timeout after %0d cycles with %0d of %0d tests done",
                 cycles, u_chk.n_done, prog.size());
        $display("Something failed");
        $finish;
      end
    end
  end

  initial begin
    exp_t e;
    rst = 1'b1;
    inst_i = '0;
    mpc = '0;
    for (int r = 0; r < 32; r++) begin
      mregs[r] = '0;
    end
    void'($urandom(32'hbbda));
    build_program();
    limit = prog.size() * 8 + 50 + 5;
    repeat (5) @(posedge clk);
    #10 rst = 1'b0;

    for (int i = 0; i < prog.size(); i++) begin
      @(negedge clk);
      while (!fetch_o) @(negedge clk);
      e = ref_exec(prog[i]);
      u_chk.add_expect(names[i], e.wen, e.rd, e.data, e.npc);
      @(posedge clk);
      #10 inst_i = prog[i];
    end
    // later fetches see an all-zero word, which the core treats as a no-op.
    @(negedge clk);
    while (!fetch_o) @(negedge clk);
    @(posedge clk);
    #10 inst_i = '0;

    wait (u_chk.n_done == prog.size());
    $display("tests: %0d, passed: %0d, failed: %0d, other errors: %0d",
             u_chk.n_done, u_chk.n_pass, u_chk.n_fail, u_chk.n_err);
    if (u_chk.n_fail == 0 && u_chk.n_err == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- wb_stage.sv
// register file with a hardwired x0, its write port and the writeback report.
`include "mc_defs.svh"

module wb_stage import mc_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  wb_t       wb_i,
  input  cnt_t      cnt_i,
  input  reg_addr_t rs1_addr_i,
  input  reg_addr_t rs2_addr_i,
  output xlen_t     rs1_data_o,
  output xlen_t     rs2_data_o,
  output wb_t       wb_o
);

  xlen_t regs [1:31]; // x0 has no storage.

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.wen && (cnt_i == `SLOT_WB1) && (wb_i.rd != '0)) begin
      regs[wb_i.rd] <= wb_i.data;
    end
  end

  assign rs1_data_o = (rs1_addr_i == '0) ? '0 : regs[rs1_addr_i];
  assign rs2_data_o = (rs2_addr_i == '0) ? '0 : regs[rs2_addr_i];

  // the top sees the write while it is pending.
  assign wb_o = wb_i;

endmodule
